/* vlog.f */
+incdir+.
cpuPkg.sv
regFile.sv
insnDecoder.sv
execUnit.sv
cpuCore.sv
progRam.sv
cpuSystem.sv
tbCpuSystem.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir
simBinary=simCpuSystem

if ! verilator --binary --timing --timescale 1ns/100ps -f vlog.f \
        --top-module tbCpuSystem -Mdir "$buildDir" -o "$simBinary"; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/$simBinary" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TEST PASS" "$logFile"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi

/* tbTestTable.svh */
`ifndef TB_TEST_TABLE_SVH
`define TB_TEST_TABLE_SVH

// One row per test with name, program words, expected store address and value and halt flag
task automatic buildTestTable();
    // Register form gives r3 = r1 op r2
    addAluCase("or",   opOr,   12'h5a3, 12'h0f0);
    addAluCase("and",  opAnd,  12'h5a3, 12'h0ff);
    addAluCase("add",  opAdd,  12'h123, 12'hf00);
    addAluCase("mul",  opMul,  12'h123, 12'hffd);
    addAluCase("shl",  opShl,  12'h5a3, 12'h007);
    addAluCase("lt",   opLt,   12'hffe, 12'h001);  // Signed compare is true
    addAluCase("eq",   opEq,   12'h321, 12'h321);
    addAluCase("gt",   opGt,   12'hffe, 12'h001);
    addAluCase("andn", opAndn, 12'h5a3, 12'h0f0);
    addAluCase("xor",  opXor,  12'h5a3, 12'hfff);
    addAluCase("sub",  opSub,  12'h100, 12'h7ff);
    addAluCase("xnor", opXnor, 12'h5a3, 12'h0f0);
    addAluCase("shr",  opShr,  12'h800, 12'h004);  // Zero fill from the top
    addAluCase("ne",   opNe,   12'h321, 12'h322);

    // Swapped form gives r3 = (r1 op imm) + r2
    addSwapCase("swap sub", opSub, 12'h050, 12'h010, 12'h003);
    addSwapCase("swap shl", opShl, 12'h003, 12'h004, 12'h100);
    addSwapCase("swap lt",  opLt,  12'hffe, 12'h001, 12'h005);
    addSwapCase("code 4",   4'h4,  12'h111, 12'h222, 12'h0ab);  // Only the addend survives
    addSwapCase("code 15",  4'hf,  12'h111, 12'h222, 12'h0cd);

    addProgram("r0 write", loadImm(4'd0, 12'h123), storeReg(4'd0, 12'h020),
               insnIllegal, insnIllegal, insnIllegal, 32'h20, 32'h0, 1'b0);
    // r15 read at word 2 gives 3
    addProgram("r15 read", loadImm(4'd1, 12'h001), loadImm(4'd2, 12'h002),
               encode(1'b0, 1'b0, 1'b0, 4'd5, 4'd15, 4'd0, opOr, 12'h000),
               storeReg(4'd5, 12'h021), insnIllegal, 32'h21, 32'h3, 1'b0);
    // Load from model word 0x15 at address r1 | r0 + 5
    addProgram("load", loadImm(4'd1, 12'h010), loadImm(4'd2, 12'h040),
               encode(1'b0, 1'b0, 1'b1, 4'd3, 4'd1, 4'd0, opOr, 12'h005),
               encode(1'b0, 1'b0, 1'b0, 4'd4, 4'd3, 4'd2, opAdd, 12'h007),
               storeReg(4'd4, 12'h022), 32'h22, dataMem[6'h15] + 32'h47, 1'b0);
    // Relative jump from word 0 to word 3 skips two stores
    addProgram("branch", encode(1'b0, 1'b0, 1'b0, 4'd15, 4'd15, 4'd0, opOr, 12'h002),
               storeReg(4'd0, 12'h03e), storeReg(4'd0, 12'h03e),
               loadImm(4'd1, 12'h05a), storeReg(4'd1, 12'h023), 32'h23, 32'h5a, 1'b0);
    // Neither the load nor the store behind the illegal word reaches the bus
    addProgram("illegal", loadImm(4'd1, 12'h077), insnIllegal,
               encode(1'b0, 1'b0, 1'b1, 4'd2, 4'd0, 4'd0, opOr, 12'h015),
               storeReg(4'd1, 12'h024), insnIllegal, 32'h0, 32'h0, 1'b1);
endtask

`endif

/* tbCpuSystem.sv */
module tbCpuSystem;
    timeunit 1ns;
    timeprecision 100ps;

    import cpuPkg::*;

    localparam int clkPeriod  = 40;
    localparam int driveDelay = 5;                 // After the rising edge
    localparam int numTests   = 24;
    localparam int maxProgLen = 8;                 // Words loaded per test
    localparam int waitLimit  = (maxProgLen + 4) * cyclesPerInsn;
    localparam int watchdogNs = numTests * clkPeriod * (waitLimit + 4 * cyclesPerInsn);
    localparam logic [31:0] lfsrSeed = 32'h80ae_8abb;
    localparam logic [31:0] lfsrTaps = 32'h8020_0003;

    logic                     clk;
    logic                     reset_n;
    logic                     en;
    logic                     loadEn;
    logic [progAddrWidth-1:0] loadAddr;
    word_t                    loadData;
    word_t                    dataAddr;
    word_t                    writeData;
    word_t                    readData;
    logic                     strobe;
    logic                     writeEn;
    logic                     halt;

    word_t dataMem [0:63];                         // Data memory model
    word_t progTable [numTests][maxProgLen];
    word_t expAddrTable [numTests];
    word_t expValueTable [numTests];
    logic  expHaltTable [numTests];
    string nameTable [numTests];
    int    entryCount;
    int    errorCount;
    int    passCount;
    int    t;

    cpuSystem i_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .en        (en),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .readData  (readData),
        .strobe    (strobe),
        .writeEn   (writeEn),
        .halt      (halt)
    );

    // Only a load strobe gets the model word back
    assign readData = (strobe && !writeEn) ? dataMem[dataAddr[5:0]] : '0;

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] stepLfsr(logic [31:0] state);
        return state[0] ? ((state >> 1) ^ lfsrTaps) : (state >> 1);
    endfunction

    task automatic seedDataMem();
        logic [31:0] state;
        word_t       value;
        int          a;
        int          b;
        state = lfsrSeed;
        for (a = 0; a < 64; a++) begin
            for (b = 0; b < dataWidth; b++) begin
                value[b] = state[0];               // One step per bit
                state    = stepLfsr(state);
            end
            dataMem[a] = value;
        end
    endtask

    function automatic word_t encode(logic swap, logic store, logic deref, regIdx_t z,
                                     regIdx_t x, regIdx_t y, logic [3:0] op, logic [11:0] imm);
        return {1'b0, swap, store, deref, z, x, y, op, imm};
    endfunction

    function automatic word_t loadImm(regIdx_t z, logic [11:0] imm);
        return encode(1'b0, 1'b0, 1'b0, z, 4'd0, 4'd0, opOr, imm);
    endfunction

    // Deref store with the address from the immediate and data from Z
    function automatic word_t storeReg(regIdx_t z, logic [11:0] addr);
        return encode(1'b0, 1'b1, 1'b1, z, 4'd0, 4'd0, opOr, addr);
    endfunction

    function automatic word_t sext(logic [11:0] v);
        return {{(dataWidth - 12){v[11]}}, v};
    endfunction

    // Operation result before the addend
    function automatic word_t aluReference(logic [3:0] code, word_t a, word_t b);
        case (code)
            opOr:    return a | b;
            opAnd:   return a & b;
            opAdd:   return a + b;
            opMul:   return a * b;
            opShl:   return (b > 32'd31) ? 32'h0 : a << b[4:0];
            opLt:    return ($signed(a) < $signed(b)) ? 32'hffff_ffff : 32'h0;
            opEq:    return (a == b) ? 32'hffff_ffff : 32'h0;
            opGt:    return ($signed(a) > $signed(b)) ? 32'hffff_ffff : 32'h0;
            opAndn:  return a & ~b;
            opXor:   return a ^ b;
            opSub:   return a - b;
            opXnor:  return ~(a ^ b);
            opShr:   return (b > 32'd31) ? 32'h0 : a >> b[4:0];
            opNe:    return (a != b) ? 32'hffff_ffff : 32'h0;
            default: return 32'h0;
        endcase
    endfunction

    task automatic addProgram(string name, word_t w0, word_t w1, word_t w2, word_t w3,
                              word_t w4, word_t addr, word_t value, logic haltExp);
        int i;
        nameTable[entryCount]    = name;
        progTable[entryCount][0] = w0;
        progTable[entryCount][1] = w1;
        progTable[entryCount][2] = w2;
        progTable[entryCount][3] = w3;
        progTable[entryCount][4] = w4;
        for (i = 5; i < maxProgLen; i++)
            progTable[entryCount][i] = insnIllegal;  // Runaway fetch halts
        expAddrTable[entryCount]  = addr;
        expValueTable[entryCount] = value;
        expHaltTable[entryCount]  = haltExp;
        entryCount++;
    endtask

    task automatic addAluCase(string name, logic [3:0] op, logic [11:0] a, logic [11:0] b);
        addProgram(name, loadImm(4'd1, a), loadImm(4'd2, b),
                   encode(1'b0, 1'b0, 1'b0, 4'd3, 4'd1, 4'd2, op, 12'h000),
                   storeReg(4'd3, 12'h010), insnIllegal,
                   32'h10, aluReference(op, sext(a), sext(b)), 1'b0);
    endtask

    task automatic addSwapCase(string name, logic [3:0] op, logic [11:0] a, logic [11:0] b,
                               logic [11:0] c);
        addProgram(name, loadImm(4'd1, a), loadImm(4'd2, c),
                   encode(1'b1, 1'b0, 1'b0, 4'd3, 4'd1, 4'd2, op, b),
                   storeReg(4'd3, 12'h011), insnIllegal,
                   32'h11, aluReference(op, sext(a), sext(b)) + sext(c), 1'b0);
    endtask

    `include "tbTestTable.svh"

    task automatic compareWord(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic compareBit(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic runTest(int idx);
        int    i;
        int    errorsBefore;
        logic  seenStore;
        logic  seenHalt;
        logic  lateAccess;
        word_t storeAddr;
        word_t storeValue;

        errorsBefore = errorCount;
        seenStore    = 1'b0;
        seenHalt     = 1'b0;
        lateAccess   = 1'b0;
        storeAddr    = '0;
        storeValue   = '0;

        @(posedge clk);
        #driveDelay;
        reset_n = 1'b0;
        en      = 1'b0;
        for (i = 0; i < maxProgLen; i++) begin
            loadEn   = 1'b1;
            loadAddr = progAddrWidth'(i);
            loadData = progTable[idx][i];
            @(posedge clk);
            #driveDelay;
        end
        loadEn = 1'b0;
        repeat (2) @(posedge clk);
        #driveDelay;
        reset_n = 1'b1;
        en      = 1'b1;

        @(negedge clk);
        compareBit("halt", halt, 1'b0);            // Clear right after reset
        compareBit("strobe", strobe, 1'b0);

        for (i = 0; i < waitLimit && !seenStore && !seenHalt; i++) begin
            @(negedge clk);
            if (strobe && writeEn) begin
                seenStore  = 1'b1;
                storeAddr  = dataAddr;
                storeValue = writeData;
                dataMem[dataAddr[5:0]] = writeData;
            end
            seenHalt = halt;
        end

        if (!seenStore && !seenHalt) begin
            $display("Test %0d failed: no store and no halt within %0d cycles", idx, waitLimit);
            errorCount++;
        end else if (expHaltTable[idx]) begin
            compareBit("halt", seenHalt, 1'b1);
            if (seenStore) begin
                $display("Test %0d failed: a store reached the bus before the halt", idx);
                errorCount++;
            end
            repeat (2 * cyclesPerInsn) begin
                @(negedge clk);
                if (strobe)
                    lateAccess = 1'b1;
            end
            if (lateAccess) begin
                $display("Test %0d failed: the halted core still drove the bus", idx);
                errorCount++;
            end
        end else begin
            compareBit("halt", seenHalt, 1'b0);
            compareWord("dataAddr", storeAddr, expAddrTable[idx]);
            compareWord("writeData", storeValue, expValueTable[idx]);
        end

        if (errorCount == errorsBefore)
            passCount++;
        $display("Test %0d %s: %s", idx, nameTable[idx],
                 (errorCount == errorsBefore) ? "passed" : "failed");
    endtask

    initial begin
        #(watchdogNs);
        $display("Watchdog expired after %0d ns and the run did not finish", watchdogNs);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        reset_n    = 1'b0;
        en         = 1'b0;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        entryCount = 0;
        errorCount = 0;
        passCount  = 0;

        seedDataMem();
        buildTestTable();                          // Load row reads the seeded model

        for (t = 0; t < entryCount; t++)
            runTest(t);

        $display("%0d tests, %0d passed, %0d failed, %0d errors", entryCount, passCount,
                 entryCount - passCount, errorCount);
        if (errorCount == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* cpuSystem.sv */
module cpuSystem (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             en,
    input  logic                             loadEn,
    input  logic [cpuPkg::progAddrWidth-1:0] loadAddr,
    input  cpuPkg::word_t                    loadData,
    output cpuPkg::word_t                    dataAddr,
    output cpuPkg::word_t                    writeData,
    input  cpuPkg::word_t                    readData,
    output logic                             strobe,
    output logic                             writeEn,
    output logic                             halt
);
    import cpuPkg::*;

    word_t fetchAddr;
    word_t fetchData;

    cpuCore i_core (
        .clk       (clk),
        .reset_n   (reset_n),
        .en        (en),
        .fetchAddr (fetchAddr),
        .fetchData (fetchData),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .readData  (readData),
        .strobe    (strobe),
        .writeEn   (writeEn),
        .halt      (halt)
    );

    progRam i_progRam (
        .clk       (clk),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .fetchAddr (fetchAddr),
        .fetchData (fetchData)
    );

endmodule

/* progRam.sv */
module progRam (
    input  logic                             clk,
    input  logic                             loadEn,
    input  logic [cpuPkg::progAddrWidth-1:0] loadAddr,
    input  cpuPkg::word_t                    loadData,
    input  cpuPkg::word_t                    fetchAddr,
    output cpuPkg::word_t                    fetchData
);
    import cpuPkg::*;

    word_t mem [0:(1 << progAddrWidth)-1];

    logic [progAddrWidth-1:0] fetchIndex;

    // Upper fetch address bits wrap around
    assign fetchIndex = fetchAddr[progAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (loadEn)
            mem[loadAddr] <= loadData;             // Filled while the core is in reset
    end

    assign fetchData = mem[fetchIndex];

endmodule

/* cpuCore.sv */
module cpuCore (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          en,
    output cpuPkg::word_t fetchAddr,
    input  cpuPkg::word_t fetchData,
    output cpuPkg::word_t dataAddr,
    output cpuPkg::word_t writeData,
    input  cpuPkg::word_t readData,
    output logic          strobe,
    output logic          writeEn,
    output logic          halt
);
    import cpuPkg::*;

    logic [cyclesPerInsn-1:0] phaseRing;           // One-hot position in the instruction
    logic [cyclesPerInsn-1:0] enableRing;          // Lags phaseRing by one step at start
    logic [cyclesPerInsn-1:0] phaseActive;

    logic    runEn;
    logic    ph0;
    logic    ph1;
    logic    ph2;
    logic    ph3;
    word_t   insnReg;
    word_t   nextPc;
    word_t   readLatch;                            // Load data from phase 1

    regIdx_t indexZ;
    regIdx_t indexX;
    regIdx_t indexY;
    aluOp_t  op;
    word_t   immValue;
    word_t   valueZ;
    word_t   valueX;
    word_t   valueY;
    word_t   aluRhs;
    word_t   rhs;
    logic    swapOperands;
    logic    storing;
    logic    derefRhs;
    logic    branch;
    logic    illegal;
    logic    loading;
    logic    storeCycle;

    assign runEn       = en && reset_n;
    assign phaseActive = phaseRing & enableRing;
    assign ph0         = phaseActive[0];
    assign ph1         = phaseActive[phaseStep];
    assign ph2         = phaseActive[2 * phaseStep];
    assign ph3         = phaseActive[3 * phaseStep];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            // Parked on the last step so phase 0 follows the first enabled edge
            phaseRing  <= {1'b1, {(cyclesPerInsn - 1){1'b0}}};
            enableRing <= '0;
            insnReg    <= insnNoop;
            fetchAddr  <= resetVector;
            nextPc     <= resetVector + word_t'(1);
            halt       <= 1'b0;
        end else if (en) begin
            phaseRing  <= {phaseRing[cyclesPerInsn-2:0], phaseRing[cyclesPerInsn-1]};
            enableRing <= {enableRing[cyclesPerInsn-2:0],
                           phaseRing[cyclesPerInsn-1] & ~halt};
            if (phaseRing[cyclesPerInsn-1])
                insnReg <= fetchData;              // Held stable for a whole instruction
            if (ph1)
                halt <= halt | illegal;
            if (ph2)
                fetchAddr <= branch ? rhs : nextPc;
            if (ph3)
                nextPc <= fetchAddr + word_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (runEn && ph1)
            readLatch <= readData;
    end

    insnDecoder i_decoder (
        .insn         (insnReg),
        .indexZ       (indexZ),
        .indexX       (indexX),
        .indexY       (indexY),
        .op           (op),
        .imm          (immValue),
        .swapOperands (swapOperands),
        .storing      (storing),
        .derefRhs     (derefRhs),
        .branch       (branch),
        .illegal      (illegal)
    );

    // Result must be ready as the load address during phase 1
    execUnit i_exec (
        .clk          (clk),
        .en           (runEn && ph0),
        .swapOperands (swapOperands),
        .op           (op),
        .x            (valueX),
        .y            (valueY),
        .imm          (immValue),
        .rhs          (aluRhs)
    );

    assign loading    = derefRhs && !storing;
    assign storeCycle = storing && ph2 && !halt;   // Illegal word never reaches the bus
    assign strobe     = (loading && ph1) || storeCycle;
    assign writeEn    = storeCycle;

    assign rhs       = derefRhs ? readLatch : aluRhs;
    assign dataAddr  = derefRhs ? aluRhs : valueZ;
    assign writeData = derefRhs ? valueZ : aluRhs;

    regFile i_regs (
        .clk        (clk),
        .en         (runEn),
        .writeEnZ   (!storing && ph3),
        .indexZ     (indexZ),
        .indexX     (indexX),
        .indexY     (indexY),
        .writeValue (rhs),
        .nextPc     (nextPc),
        .valueZ     (valueZ),
        .valueX     (valueX),
        .valueY     (valueY)
    );

endmodule

/* execUnit.sv */
module execUnit (
    input  logic           clk,
    input  logic           en,
    input  logic           swapOperands,
    input  cpuPkg::aluOp_t op,
    input  cpuPkg::word_t  x,
    input  cpuPkg::word_t  y,
    input  cpuPkg::word_t  imm,
    output cpuPkg::word_t  rhs
);
    import cpuPkg::*;

    word_t operand;                                // Second ALU operand
    word_t addend;                                 // Added after the operation
    word_t result;
    logic  isLess;
    logic  isGreater;
    logic  isEqual;

    assign operand = swapOperands ? imm : y;
    assign addend  = swapOperands ? y : imm;

    // Comparisons are signed
    assign isLess    = $signed(x) < $signed(operand);
    assign isGreater = $signed(x) > $signed(operand);
    assign isEqual   = (x == operand);

    always_ff @(posedge clk) begin
        if (en) begin
            case (op)
                opOr:    result <= x | operand;
                opAnd:   result <= x & operand;
                opAdd:   result <= x + operand;
                opMul:   result <= x * operand;       // Low word only
                opShl:   result <= x << operand;
                opLt:    result <= {dataWidth{isLess}};
                opEq:    result <= {dataWidth{isEqual}};
                opGt:    result <= {dataWidth{isGreater}};
                opAndn:  result <= x & ~operand;
                opXor:   result <= x ^ operand;
                opSub:   result <= x - operand;
                opXnor:  result <= x ^~ operand;
                opShr:   result <= x >> operand;      // Logical shift
                opNe:    result <= {dataWidth{!isEqual}};
                default: result <= '0;                // Codes 4 and 15
            endcase
        end
    end

    assign rhs = result + addend;

endmodule

/* insnDecoder.sv */
module insnDecoder (
    input  cpuPkg::word_t   insn,
    output cpuPkg::regIdx_t indexZ,
    output cpuPkg::regIdx_t indexX,
    output cpuPkg::regIdx_t indexY,
    output cpuPkg::aluOp_t  op,
    output cpuPkg::word_t   imm,
    output logic            swapOperands,
    output logic            storing,
    output logic            derefRhs,
    output logic            branch,
    output logic            illegal
);
    import cpuPkg::*;

    logic [11:0] immField;

    assign swapOperands = insn[30];                // Type bit
    assign storing      = insn[29];
    assign derefRhs     = insn[28];
    assign indexZ       = insn[27:24];
    assign indexX       = insn[23:20];
    assign indexY       = insn[19:16];
    assign op           = aluOp_t'(insn[15:12]);   // Reserved codes pass through
    assign immField     = insn[11:0];

    assign imm = {{(dataWidth - 12){immField[11]}}, immField};

    // Writing r15 redirects the fetch
    assign branch  = (indexZ == regIdx_t'(15)) && !storing;
    assign illegal = (insn == insnIllegal);

endmodule

/* regFile.sv */
module regFile (
    input  logic            clk,
    input  logic            en,
    input  logic            writeEnZ,
    input  cpuPkg::regIdx_t indexZ,
    input  cpuPkg::regIdx_t indexX,
    input  cpuPkg::regIdx_t indexY,
    input  cpuPkg::word_t   writeValue,
    input  cpuPkg::word_t   nextPc,
    output cpuPkg::word_t   valueZ,
    output cpuPkg::word_t   valueX,
    output cpuPkg::word_t   valueY
);
    import cpuPkg::*;

    word_t regs [1:14];                            // r0 and r15 are not stored

    function automatic word_t readPort(regIdx_t idx);
        word_t value;
        if (idx == regIdx_t'(0))
            value = '0;                            // Hard-wired zero
        else if (idx == regIdx_t'(15))
            value = nextPc;                        // Program counter view
        else
            value = regs[idx];
        return value;
    endfunction

    always_comb begin
        valueZ = readPort(indexZ);
        valueX = readPort(indexX);
        valueY = readPort(indexY);
    end

    always_ff @(posedge clk) begin
        if (en && writeEnZ && indexZ != regIdx_t'(0) && indexZ != regIdx_t'(15))
            regs[indexZ] <= writeValue;
    end

endmodule

/* cpuPkg.sv */
package cpuPkg;

    localparam int dataWidth     = 32;
    localparam int regIndexWidth = 4;
    localparam int progAddrWidth = 8;              // 256 program words

    // Must be a multiple of 4 and at least 4
    localparam int cyclesPerInsn = 8;
    localparam int phaseStep     = cyclesPerInsn / 4; // Ring distance between phases

    typedef logic [dataWidth-1:0]     word_t;
    typedef logic [regIndexWidth-1:0] regIdx_t;

    localparam word_t resetVector = 32'h0000_0000; // First fetch address

    // r0 = r0 | r0 + 0, nothing visible changes
    localparam word_t insnNoop    = 32'h0000_0000;
    localparam word_t insnIllegal = 32'hffff_ffff; // Halts the core

    // Codes 4 and 15 are reserved and yield zero
    typedef enum logic [3:0] {
        opOr   = 4'h0,
        opAnd  = 4'h1,
        opAdd  = 4'h2,
        opMul  = 4'h3,
        opShl  = 4'h5,
        opLt   = 4'h6,
        opEq   = 4'h7,
        opGt   = 4'h8,
        opAndn = 4'h9,
        opXor  = 4'ha,
        opSub  = 4'hb,
        opXnor = 4'hc,
        opShr  = 4'hd,
        opNe   = 4'he
    } aluOp_t;

endpackage
